/* Makefile */
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f tb.f --top-module rv_core_tb -o rv_core_tb

run: compile
	./obj_dir/rv_core_tb +verilator+error+limit+1000 > sim.log 2>&1 || true
	cat sim.log
	grep -q '^TEST PASS$$' sim.log

clean:
	rm -rf obj_dir sim.log

/* source/rv_alu.sv */
`timescale 1ns/1ps

module rv_alu (
  input  rv_pkg::word_t   a,
  input  rv_pkg::word_t   b,
  input  rv_pkg::alu_op_t alu_op,
  input  logic [2:0]      funct3,
  output rv_pkg::word_t   result,
  output logic            taken
);
  import rv_pkg::*;

  logic [4:0] shamt;
  logic       zero;

  assign shamt = b[4:0];

  always_comb begin
    case (alu_op)
      alu_add:  result = a + b;
      alu_sub:  result = a - b;
      alu_slt:  result = {31'd0, $signed(a) < $signed(b)};
      alu_sltu: result = {31'd0, a < b};
      alu_xor:  result = a ^ b;
      alu_or:   result = a | b;
      alu_and:  result = a & b;
      alu_sll:  result = a << shamt;
      alu_srl:  result = a >> shamt;
      alu_sra:  result = word_t'($signed(a) >>> shamt);
      default:  result = a + b;
    endcase
  end

  // sub gives zero on equal, slt and sltu give zero when not less
  assign zero = (result == '0);

  always_comb begin
    case (funct3)
      f3_beq:  taken = zero;
      f3_bne:  taken = !zero;
      f3_blt:  taken = !zero;
      f3_bge:  taken = zero;
      f3_bltu: taken = !zero;
      f3_bgeu: taken = zero;
      default: taken = 1'b0;
    endcase
  end

endmodule

/* source/rv_commit.sv */
`timescale 1ns/1ps

module rv_commit #(
  parameter rv_pkg::word_t reset_pc = '0
) (
  input  logic            clk,
  input  logic            rst,
  input  rv_pkg::word_t   imm,
  input  rv_pkg::word_t   rs1_val,
  input  rv_pkg::word_t   alu_result,
  input  logic            taken,
  input  rv_pkg::word_t   load_val,
  input  rv_pkg::wb_sel_t wb_sel,
  input  logic            is_branch,
  input  logic            is_jal,
  input  logic            is_jalr,
  input  logic            is_auipc,
  input  logic            reg_write_req,
  input  logic [3:0]      store_we_req,
  output rv_pkg::word_t   pc,
  output logic            reg_write,
  output rv_pkg::word_t   rd_data,
  output logic [3:0]      store_we
);
  import rv_pkg::*;

  word_t pc_plus4;
  word_t pc_target;
  word_t next_pc;

  assign pc_plus4  = pc + xlen'(4);
  assign pc_target = pc + imm;

  always_comb begin
    case (wb_sel)
      wb_alu:   rd_data = alu_result;
      wb_load:  rd_data = load_val;
      wb_pc4:   rd_data = pc_plus4;
      default:  rd_data = is_auipc ? pc_target : imm;
    endcase
  end

  // jalr target keeps the pc word aligned
  always_comb begin
    if (is_jalr) begin
      next_pc = (rs1_val + imm) & ~word_t'(3);
    end else if (is_jal || (is_branch && taken)) begin
      next_pc = pc_target;
    end else begin
      next_pc = pc_plus4;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= reset_pc;
    end else begin
      pc <= next_pc;
    end
  end

  // nothing architectural changes while in reset
  assign reg_write = reg_write_req & ~rst;
  assign store_we  = rst ? 4'b0000 : store_we_req;

endmodule

/* source/rv_core.sv */
`timescale 1ns/1ps

module rv_core #(
  parameter int            num_regs = 32,
  parameter rv_pkg::word_t reset_pc = '0
) (
  input  logic          clk,
  input  logic          rst,
  input  rv_pkg::insn_t insn,
  input  rv_pkg::word_t load_data,
  output rv_pkg::word_t pc,
  output rv_pkg::word_t dmem_addr,
  output rv_pkg::word_t store_data,
  output logic [3:0]    store_we,
  output logic          halt
);
  import rv_pkg::*;

  logic [4:0] rs1;
  logic [4:0] rs2;
  logic [4:0] rd;
  word_t      imm;
  alu_op_t    alu_op;
  logic       alu_use_imm;
  mem_size_t  mem_size;
  logic       load_unsigned;
  logic       is_load;
  logic       is_store;
  logic       is_branch;
  logic       is_jal;
  logic       is_jalr;
  logic       is_auipc;
  logic       reg_write_req;
  wb_sel_t    wb_sel;
  word_t      rs1_val;
  word_t      rs2_val;
  word_t      alu_b;
  word_t      alu_result;
  logic       taken;
  word_t      load_val;
  logic [3:0] lsu_store_we;
  logic       reg_write;
  word_t      rd_data;

  rv_decode u_decode (
    .insn(insn), .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm),
    .alu_op(alu_op), .alu_use_imm(alu_use_imm), .mem_size(mem_size),
    .load_unsigned(load_unsigned), .is_load(is_load), .is_store(is_store),
    .is_branch(is_branch), .is_jal(is_jal), .is_jalr(is_jalr),
    .is_auipc(is_auipc), .reg_write(reg_write_req), .wb_sel(wb_sel), .halt(halt)
  );

  rv_regfile #(.num_regs(num_regs)) u_regfile (
    .clk(clk), .rst(rst), .we(reg_write), .rd(rd), .rd_data(rd_data),
    .rs1(rs1), .rs2(rs2), .rs1_val(rs1_val), .rs2_val(rs2_val)
  );

  assign alu_b = alu_use_imm ? imm : rs2_val;

  rv_alu u_alu (
    .a(rs1_val), .b(alu_b), .alu_op(alu_op), .funct3(insn.r.funct3),
    .result(alu_result), .taken(taken)
  );

  rv_lsu u_lsu (
    .base(rs1_val), .offset(imm), .store_val(rs2_val), .mem_size(mem_size),
    .load_unsigned(load_unsigned), .is_load(is_load), .is_store(is_store),
    .load_data(load_data), .dmem_addr(dmem_addr), .store_data(store_data),
    .store_we(lsu_store_we), .load_val(load_val)
  );

  rv_commit #(.reset_pc(reset_pc)) u_commit (
    .clk(clk), .rst(rst), .imm(imm), .rs1_val(rs1_val), .alu_result(alu_result),
    .taken(taken), .load_val(load_val), .wb_sel(wb_sel), .is_branch(is_branch),
    .is_jal(is_jal), .is_jalr(is_jalr), .is_auipc(is_auipc),
    .reg_write_req(reg_write_req), .store_we_req(lsu_store_we), .pc(pc),
    .reg_write(reg_write), .rd_data(rd_data), .store_we(store_we)
  );

endmodule

/* source/rv_decode.sv */
`timescale 1ns/1ps

module rv_decode (
  input  rv_pkg::insn_t     insn,
  output logic [4:0]        rs1,
  output logic [4:0]        rs2,
  output logic [4:0]        rd,
  output rv_pkg::word_t     imm,
  output rv_pkg::alu_op_t   alu_op,
  output logic              alu_use_imm,
  output rv_pkg::mem_size_t mem_size,
  output logic              load_unsigned,
  output logic              is_load,
  output logic              is_store,
  output logic              is_branch,
  output logic              is_jal,
  output logic              is_jalr,
  output logic              is_auipc,
  output logic              reg_write,
  output rv_pkg::wb_sel_t   wb_sel,
  output logic              halt
);
  import rv_pkg::*;

  word_t imm_i;
  word_t imm_s;
  word_t imm_b;
  word_t imm_j;
  word_t imm_u;
  logic [2:0] funct3;

  // funct7 bit 5 picks sub and sra
  function automatic alu_op_t arith_op(logic [2:0] f3, logic alt, logic reg_form);
    alu_op_t op;
    case (f3)
      f3_add_sub: op = (alt && reg_form) ? alu_sub : alu_add;
      f3_sll:     op = alu_sll;
      f3_slt:     op = alu_slt;
      f3_sltu:    op = alu_sltu;
      f3_xor:     op = alu_xor;
      f3_srl_sra: op = alt ? alu_sra : alu_srl;
      f3_or:      op = alu_or;
      f3_and:     op = alu_and;
      default:    op = alu_add;
    endcase
    return op;
  endfunction

  assign rs1    = insn.r.rs1;
  assign rs2    = insn.r.rs2;
  assign rd     = insn.r.rd;
  assign funct3 = insn.r.funct3;

  assign imm_i = {{20{insn.r.funct7[6]}}, insn.r.funct7, insn.r.rs2};
  assign imm_s = {{20{insn.r.funct7[6]}}, insn.r.funct7, insn.r.rd};
  assign imm_b = {{20{insn.r.funct7[6]}}, insn.r.rd[0], insn.r.funct7[5:0],
                  insn.r.rd[4:1], 1'b0};
  // J bits are scrambled inside the upper 20
  assign imm_j = {{12{insn.uj.imm20[19]}}, insn.uj.imm20[7:0], insn.uj.imm20[8],
                  insn.uj.imm20[18:9], 1'b0};
  assign imm_u = {insn.uj.imm20, 12'd0};

  assign mem_size      = mem_size_t'(funct3[1:0]);
  assign load_unsigned = funct3[2];

  always_comb begin
    imm         = imm_i;
    alu_op      = alu_add;
    alu_use_imm = 1'b0;
    is_load     = 1'b0;
    is_store    = 1'b0;
    is_branch   = 1'b0;
    is_jal      = 1'b0;
    is_jalr     = 1'b0;
    is_auipc    = 1'b0;
    reg_write   = 1'b0;
    wb_sel      = wb_alu;
    halt        = 1'b0;
    case (insn.r.opcode)
      opc_lui: begin
        imm       = imm_u;
        reg_write = 1'b1;
        wb_sel    = wb_upper;
      end
      opc_auipc: begin
        imm       = imm_u;
        is_auipc  = 1'b1;
        reg_write = 1'b1;
        wb_sel    = wb_upper;
      end
      opc_op_imm: begin
        alu_op      = arith_op(funct3, insn.r.funct7[5], 1'b0);
        alu_use_imm = 1'b1;
        reg_write   = 1'b1;
      end
      opc_op: begin
        alu_op    = arith_op(funct3, insn.r.funct7[5], 1'b1);
        reg_write = 1'b1;
      end
      opc_branch: begin
        imm       = imm_b;
        is_branch = 1'b1;
        // the alu compare result feeds the taken decision
        case (funct3)
          f3_beq, f3_bne:   alu_op = alu_sub;
          f3_blt, f3_bge:   alu_op = alu_slt;
          f3_bltu, f3_bgeu: alu_op = alu_sltu;
          default:          alu_op = alu_sub;
        endcase
      end
      opc_jal: begin
        imm       = imm_j;
        is_jal    = 1'b1;
        reg_write = 1'b1;
        wb_sel    = wb_pc4;
      end
      opc_jalr: begin
        is_jalr   = 1'b1;
        reg_write = 1'b1;
        wb_sel    = wb_pc4;
      end
      opc_load: begin
        is_load   = 1'b1;
        reg_write = 1'b1;
        wb_sel    = wb_load;
      end
      opc_store: begin
        imm      = imm_s;
        is_store = 1'b1;
      end
      opc_system: begin
        // only ECALL, every other field zero
        halt = ({insn.uj.imm20, insn.uj.rd} == 25'd0);
      end
      default: begin
      end
    endcase
  end

endmodule

/* source/rv_lsu.sv */
`timescale 1ns/1ps

module rv_lsu (
  input  rv_pkg::word_t     base,
  input  rv_pkg::word_t     offset,
  input  rv_pkg::word_t     store_val,
  input  rv_pkg::mem_size_t mem_size,
  input  logic              load_unsigned,
  input  logic              is_load,
  input  logic              is_store,
  input  rv_pkg::word_t     load_data,
  output rv_pkg::word_t     dmem_addr,
  output rv_pkg::word_t     store_data,
  output logic [3:0]        store_we,
  output rv_pkg::word_t     load_val
);
  import rv_pkg::*;

  word_t      eff_addr;
  logic [1:0] byte_off;
  word_t      shifted;
  logic [3:0] lanes;

  assign eff_addr  = base + offset;
  assign byte_off  = eff_addr[1:0];
  assign dmem_addr = {eff_addr[xlen-1:2], 2'b00};

  // replicate so the addressed lanes always hold the value
  always_comb begin
    case (mem_size)
      size_byte: begin
        store_data = {4{store_val[7:0]}};
        lanes      = 4'b0001 << byte_off;
      end
      size_half: begin
        store_data = {2{store_val[15:0]}};
        lanes      = byte_off[1] ? 4'b1100 : 4'b0011;
      end
      default: begin
        store_data = store_val;
        lanes      = 4'b1111;
      end
    endcase
  end

  assign store_we = is_store ? lanes : 4'b0000;

  // move the addressed byte or half down to bit 0
  assign shifted = load_data >> {byte_off, 3'b000};

  always_comb begin
    load_val = '0;
    if (is_load) begin
      case (mem_size)
        size_byte: load_val = {{24{shifted[7] & ~load_unsigned}}, shifted[7:0]};
        size_half: load_val = {{16{shifted[15] & ~load_unsigned}}, shifted[15:0]};
        default:   load_val = load_data;
      endcase
    end
  end

endmodule

/* source/rv_pkg.sv */
package rv_pkg;

  localparam int xlen = 32;

  typedef logic [xlen-1:0] word_t;

  // major opcodes, bits [6:0] of the instruction
  typedef enum logic [6:0] {
    opc_load   = 7'b0000011,
    opc_store  = 7'b0100011,
    opc_branch = 7'b1100011,
    opc_jalr   = 7'b1100111,
    opc_jal    = 7'b1101111,
    opc_op_imm = 7'b0010011,
    opc_op     = 7'b0110011,
    opc_system = 7'b1110011,
    opc_auipc  = 7'b0010111,
    opc_lui    = 7'b0110111
  } opcode_t;

  // funct3 for OP and OP-IMM
  localparam logic [2:0] f3_add_sub = 3'b000;
  localparam logic [2:0] f3_sll     = 3'b001;
  localparam logic [2:0] f3_slt     = 3'b010;
  localparam logic [2:0] f3_sltu    = 3'b011;
  localparam logic [2:0] f3_xor     = 3'b100;
  localparam logic [2:0] f3_srl_sra = 3'b101;
  localparam logic [2:0] f3_or      = 3'b110;
  localparam logic [2:0] f3_and     = 3'b111;

  // funct3 for BRANCH
  localparam logic [2:0] f3_beq  = 3'b000;
  localparam logic [2:0] f3_bne  = 3'b001;
  localparam logic [2:0] f3_blt  = 3'b100;
  localparam logic [2:0] f3_bge  = 3'b101;
  localparam logic [2:0] f3_bltu = 3'b110;
  localparam logic [2:0] f3_bgeu = 3'b111;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_slt, alu_sltu, alu_xor,
    alu_or, alu_and, alu_sll, alu_srl, alu_sra
  } alu_op_t;

  // matches funct3[1:0] of loads and stores
  typedef enum logic [1:0] {
    size_byte = 2'b00,
    size_half = 2'b01,
    size_word = 2'b10
  } mem_size_t;

  typedef enum logic [1:0] {
    wb_alu, wb_load, wb_pc4, wb_upper
  } wb_sel_t;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    opcode_t    opcode;
  } insn_r_t;

  typedef struct packed {
    logic [19:0] imm20;
    logic [4:0]  rd;
    opcode_t     opcode;
  } insn_uj_t;

  typedef union packed {
    insn_r_t  r;
    insn_uj_t uj;
  } insn_t;

endpackage

/* source/rv_regfile.sv */
`timescale 1ns/1ps

module rv_regfile #(
  parameter int num_regs = 32
) (
  input  logic          clk,
  input  logic          rst,
  input  logic          we,
  input  logic [4:0]    rd,
  input  rv_pkg::word_t rd_data,
  input  logic [4:0]    rs1,
  input  logic [4:0]    rs2,
  output rv_pkg::word_t rs1_val,
  output rv_pkg::word_t rs2_val
);
  import rv_pkg::*;

  localparam int idx_w = $clog2(num_regs);

  word_t regs [num_regs];

  // indices past the end of a reduced file behave like x0
  function automatic logic in_file(logic [4:0] idx);
    return (idx != 5'd0) && (32'(idx) < num_regs);
  endfunction

  assign rs1_val = in_file(rs1) ? regs[rs1[idx_w-1:0]] : '0;
  assign rs2_val = in_file(rs2) ? regs[rs2[idx_w-1:0]] : '0;

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (we && in_file(rd)) begin
      regs[rd[idx_w-1:0]] <= rd_data;
    end
  end

endmodule

/* tb.f */
source/rv_pkg.sv
source/rv_regfile.sv
source/rv_decode.sv
source/rv_alu.sv
source/rv_lsu.sv
source/rv_commit.sv
source/rv_core.sv
verification/rv_core_chk.sv
verification/rv_core_tb.sv

/* verification/rv_core_chk.sv */
`timescale 1ns/1ps

module rv_core_chk #(
  parameter rv_pkg::word_t reset_pc = '0
) (
  input logic          clk,
  input logic          rst,
  input rv_pkg::insn_t insn,
  input rv_pkg::word_t pc,
  input rv_pkg::word_t dmem_addr,
  input logic [3:0]    store_we,
  input logic          halt
);
  import rv_pkg::*;

  int   fails = 0;
  logic is_flow;

  // branches, jumps and ECALL may leave the pc+4 path
  assign is_flow = (insn.r.opcode inside {opc_branch, opc_jal, opc_jalr}) || halt;

  a_addr_aligned: assert property (@(posedge clk) dmem_addr[1:0] == 2'b00)
    else begin
      fails++;
      $error("data address %h is not word aligned", dmem_addr);
    end

  a_lane_shape: assert property (@(posedge clk)
      store_we inside {4'b0000, 4'b0001, 4'b0010, 4'b0100, 4'b1000,
                       4'b0011, 4'b1100, 4'b1111})
    else begin
      fails++;
      $error("store lane enables %b are not a byte, half or word", store_we);
    end

  a_reset_quiet: assert property (@(posedge clk)
      rst |-> (store_we == 4'b0000) && (!$past(rst) || pc == reset_pc))
    else begin
      fails++;
      $error("core is not quiet in reset, pc %h lanes %b", pc, store_we);
    end

  a_pc_step: assert property (@(posedge clk) disable iff (rst)
      !is_flow |=> pc == $past(pc) + 32'd4)
    else begin
      fails++;
      $error("pc %h did not step by 4", pc);
    end

endmodule

bind rv_core rv_core_chk #(.reset_pc(reset_pc)) u_chk (
  .clk(clk), .rst(rst), .insn(insn), .pc(pc), .dmem_addr(dmem_addr),
  .store_we(store_we), .halt(halt)
);

/* verification/rv_core_tb.sv */
`timescale 1ns/1ps

module rv_core_tb;
  import rv_pkg::*;

  localparam int          mem_words = 1024;
  localparam int          data_word = 512;
  localparam logic [31:0] data_base = 32'h800;

  // funct3 and funct7[5] of the ten register-register operations
  localparam logic [2:0] r_f3 [10] = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3,
                                       3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
  localparam logic       r_alt [10] = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0,
                                        1'b0, 1'b0, 1'b1, 1'b0, 1'b0};
  localparam logic [2:0] br_f3 [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};

  logic       clk = 1'b0;
  logic       rst;
  insn_t      insn;
  word_t      load_data;
  word_t      pc;
  word_t      dmem_addr;
  word_t      store_data;
  logic [3:0] store_we;
  logic       halt;

  word_t       mem [mem_words];
  word_t       exp_val [256];
  string       names [16];
  int          first_slot [17];
  int          wp;
  int          slot;
  int          ntests;
  int          errors;
  int          checks;
  int          limit;
  int          cycles = 0;
  logic [31:0] seed;

  rv_core #(.num_regs(32), .reset_pc('0)) DUT (
    .clk(clk), .rst(rst), .insn(insn), .load_data(load_data), .pc(pc),
    .dmem_addr(dmem_addr), .store_data(store_data), .store_we(store_we), .halt(halt)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    if (!rst) begin
      cycles <= cycles + 1;
    end
  end

  // memory model with combinational reads and byte writes at the edge
  assign insn      = insn_t'(mem[pc[11:2]]);
  assign load_data = mem[dmem_addr[11:2]];

  always @(posedge clk) begin
    for (int i = 0; i < 4; i++) begin
      if (store_we[i]) begin
        mem[dmem_addr[11:2]][i*8 +: 8] <= store_data[i*8 +: 8];
      end
    end
  end

  function automatic word_t fill(word_t addr);
    return (addr * 32'h2545f491) ^ 32'h6c8e9cf5;
  endfunction

  function automatic word_t lcg();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic word_t alu_ref(logic [2:0] f3, logic alt, word_t a, word_t b);
    word_t r;
    case (f3)
      3'd0: r = alt ? a - b : a + b;
      3'd1: r = a << b[4:0];
      3'd2: r = {31'd0, $signed(a) < $signed(b)};
      3'd3: r = {31'd0, a < b};
      3'd4: r = a ^ b;
      3'd5: r = alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6: r = a | b;
      default: r = a & b;
    endcase
    return r;
  endfunction

  function automatic logic branch_ref(logic [2:0] f3, word_t a, word_t b);
    case (f3)
      3'd0: return a == b;
      3'd1: return a != b;
      3'd4: return $signed(a) < $signed(b);
      3'd5: return $signed(a) >= $signed(b);
      3'd6: return a < b;
      default: return a >= b;
    endcase
  endfunction

  task automatic emit(insn_t w);
    mem[wp] = w;
    wp++;
  endtask

  task automatic op_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1, logic [2:0] f3,
                      logic [4:0] rd, opcode_t opc);
    insn_t w;
    w.r.funct7 = f7;
    w.r.rs2    = rs2;
    w.r.rs1    = rs1;
    w.r.funct3 = f3;
    w.r.rd     = rd;
    w.r.opcode = opc;
    emit(w);
  endtask

  task automatic op_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3, logic [4:0] rd,
                      opcode_t opc);
    op_r(imm[11:5], imm[4:0], rs1, f3, rd, opc);
  endtask

  task automatic op_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1, logic [2:0] f3);
    op_r(imm[11:5], rs2, rs1, f3, imm[4:0], opc_store);
  endtask

  task automatic op_b(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1, logic [2:0] f3);
    op_r({imm[12], imm[10:5]}, rs2, rs1, f3, {imm[4:1], imm[11]}, opc_branch);
  endtask

  task automatic op_u(logic [19:0] imm20, logic [4:0] rd, opcode_t opc);
    insn_t w;
    w.uj.imm20  = imm20;
    w.uj.rd     = rd;
    w.uj.opcode = opc;
    emit(w);
  endtask

  task automatic op_j(logic [20:0] imm, logic [4:0] rd);
    op_u({imm[20], imm[10:1], imm[11], imm[19:12]}, rd, opc_jal);
  endtask

  // lui plus addi with the carry out of the low 12 bits folded in
  task automatic li(logic [4:0] rd, word_t v);
    word_t hi;
    hi = v + 32'h800;
    op_u(hi[31:12], rd, opc_lui);
    op_i(v[11:0], rd, 3'd0, rd, opc_op_imm);
  endtask

  task automatic expect_slot(word_t e);
    exp_val[slot] = e;
    slot++;
  endtask

  task automatic store_result(logic [4:0] rs, word_t e);
    op_s(12'(slot * 4), rs, 5'd10, 3'b010);
    expect_slot(e);
  endtask

  task automatic begin_test(string n);
    names[ntests]      = n;
    first_slot[ntests] = slot;
    ntests++;
  endtask

  initial begin
    word_t       a;
    word_t       b;
    word_t       v;
    word_t       w;
    word_t       got;
    logic [11:0] imm;
    logic [2:0]  f3;
    int          base_pc;
    int          ls;
    logic        bad;
    rst    = 1'b1;
    seed   = 32'hd93c;
    wp     = 0;
    slot   = 0;
    ntests = 0;
    errors = 0;
    checks = 0;
    for (int i = 0; i < mem_words; i++) begin
      mem[i] = fill(32'(i) * 4);
    end
    // a store at the reset pc is held off in reset and writes an unused word after it
    op_s(12'h7fc, 5'd0, 5'd0, 3'b010);
    li(5'd10, data_base);

    begin_test("alu_reg");
    for (int k = 0; k < 10; k++) begin
      a = lcg();
      b = lcg();
      li(5'd1, a);
      li(5'd2, b);
      op_r({1'b0, r_alt[k], 5'd0}, 5'd2, 5'd1, r_f3[k], 5'd3, opc_op);
      store_result(5'd3, alu_ref(r_f3[k], r_alt[k], a, b));
    end

    begin_test("alu_imm");
    a = lcg();
    li(5'd1, a);
    for (int k = 0; k < 9; k++) begin
      f3 = (k == 8) ? 3'd5 : 3'(k);
      v  = lcg();
      if (f3 == 3'd1 || f3 == 3'd5) begin
        imm = {1'b0, k == 8, 5'd0, v[4:0]};
      end else begin
        imm = v[11:0];
      end
      b = {{20{imm[11]}}, imm};
      op_i(imm, 5'd1, f3, 5'd3, opc_op_imm);
      store_result(5'd3, alu_ref(f3, k == 8, a, b));
    end

    begin_test("upper");
    v = lcg();
    op_u(v[19:0], 5'd3, opc_lui);
    store_result(5'd3, {v[19:0], 12'd0});
    v       = lcg();
    base_pc = wp * 4;
    op_u(v[19:0], 5'd3, opc_auipc);
    store_result(5'd3, 32'(base_pc) + {v[19:0], 12'd0});

    // equal, random, and a pair where signed and unsigned order disagree
    begin_test("branch");
    for (int k = 0; k < 3; k++) begin
      case (k)
        0: begin
          a = lcg();
          b = a;
        end
        1: begin
          a = lcg();
          b = lcg();
        end
        default: begin
          a = 32'hffff_fff0;
          b = 32'h0000_0010;
        end
      endcase
      li(5'd1, a);
      li(5'd2, b);
      for (int j = 0; j < 6; j++) begin
        op_i(12'h011, 5'd0, 3'd0, 5'd4, opc_op_imm);
        op_b(13'd8, 5'd2, 5'd1, br_f3[j]);
        op_i(12'h022, 5'd0, 3'd0, 5'd4, opc_op_imm);
        store_result(5'd4, branch_ref(br_f3[j], a, b) ? 32'h11 : 32'h22);
      end
    end

    begin_test("jump");
    op_i(12'h033, 5'd0, 3'd0, 5'd4, opc_op_imm);
    base_pc = wp * 4;
    op_j(21'd8, 5'd6);
    op_i(12'h044, 5'd0, 3'd0, 5'd4, opc_op_imm);
    store_result(5'd4, 32'h33);
    store_result(5'd6, 32'(base_pc) + 4);
    // jalr to auipc+21 lands on the even target auipc+20
    base_pc = wp * 4;
    op_u(20'd0, 5'd7, opc_auipc);
    op_i(12'h055, 5'd0, 3'd0, 5'd4, opc_op_imm);
    op_i(12'd21, 5'd7, 3'd0, 5'd8, opc_jalr);
    op_i(12'h066, 5'd0, 3'd0, 5'd4, opc_op_imm);
    op_i(12'h077, 5'd0, 3'd0, 5'd4, opc_op_imm);
    store_result(5'd4, 32'h55);
    store_result(5'd8, 32'(base_pc) + 12);

    begin_test("store_part");
    for (int o = 0; o < 4; o++) begin
      v = lcg();
      li(5'd1, v);
      w = fill(data_base + 32'(slot) * 4);
      w[o*8 +: 8] = v[7:0];
      op_s(12'(slot * 4 + o), 5'd1, 5'd10, 3'b000);
      expect_slot(w);
    end
    for (int o = 0; o < 4; o += 2) begin
      v = lcg();
      li(5'd1, v);
      w = fill(data_base + 32'(slot) * 4);
      w[o*8 +: 16] = v[15:0];
      op_s(12'(slot * 4 + o), 5'd1, 5'd10, 3'b001);
      expect_slot(w);
    end

    begin_test("load_ext");
    w  = 32'h8a7b1cf3;
    ls = slot;
    li(5'd1, w);
    store_result(5'd1, w);
    for (int o = 0; o < 4; o++) begin
      for (int u = 0; u < 2; u++) begin
        v = w >> (o * 8);
        op_i(12'(ls * 4 + o), 5'd10, {u[0], 2'b00}, 5'd3, opc_load);
        store_result(5'd3, u[0] ? {24'd0, v[7:0]} : {{24{v[7]}}, v[7:0]});
        if (o % 2 == 0) begin
          op_i(12'(ls * 4 + o), 5'd10, {u[0], 2'b01}, 5'd3, opc_load);
          store_result(5'd3, u[0] ? {16'd0, v[15:0]} : {{16{v[15]}}, v[15:0]});
        end
      end
    end

    begin_test("x0_halt");
    op_i(12'd123, 5'd0, 3'd0, 5'd0, opc_op_imm);
    store_result(5'd0, 32'd0);
    emit(insn_t'(32'h0000_0073));
    first_slot[ntests] = slot;
    limit = 2 * wp + 50;

    repeat (16) @(posedge clk);
    #1 rst = 1'b0;
    while (!halt && cycles < limit) begin
      @(negedge clk);
    end

    if (!halt) begin
      $display("timeout: the core did not reach ECALL within %0d cycles", limit);
      errors++;
    end else begin
      for (int t = 0; t < ntests; t++) begin
        bad = 1'b0;
        for (int s = first_slot[t]; s < first_slot[t+1]; s++) begin
          checks++;
          got = mem[data_word + s];
          assert (got == exp_val[s]) else begin
            $display("ERR %s slot %0d expected %08h actual %08h",
                     names[t], s, exp_val[s], got);
            errors++;
            bad = 1'b1;
          end
        end
        $display("%s %s", names[t], bad ? "failed" : "ok");
      end
    end
    if (DUT.u_chk.fails != 0) begin
      $display("%0d assertion failures on the core ports", DUT.u_chk.fails);
      errors += DUT.u_chk.fails;
    end
    $display("tests %0d checks %0d errors %0d", ntests, checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule
